// File: verilog/usb_cmd_config.svh
`ifndef USB_CMD_CONFIG_SVH
`define USB_CMD_CONFIG_SVH

//////////////////////////////////////////
// Exact command codes
//////////////////////////////////////////
`define CMD_TRIG_MODE_INSIDE   16'haa01
`define CMD_TRIG_MODE_EXT      16'haa02
`define CMD_TRIG_MODE_SELF_OR  16'haa03
`define CMD_TRIG_MODE_SELF_AND 16'haa04
`define CMD_TRIG_START         16'h00a1
`define CMD_TRIG_STOP          16'h00a0
`define CMD_HOLD_ON            16'hffb1
`define CMD_HOLD_OFF           16'hffb0
`define CMD_ACQ_START          16'hf0f1
`define CMD_ACQ_STOP           16'hf0f0
`define CMD_LED_ALL            16'h55aa
`define CMD_LED_DIM            16'h45aa
`define CMD_CONFIG_START       16'h00b1
`define CMD_ASIC_RESET         16'hffc0
`define CMD_FORCE_TRIG         16'hffe0

// Prefix codes, upper nibble or upper byte
`define PFX_DAC12      4'h1
`define PFX_DAC34      4'h4
`define PFX_CALI_DAC   4'h5
`define PFX_HOLD_DELAY 4'h6
`define PFX_CHAN_SEL   8'h34
`define PFX_LED        8'h00

//////////////////////////////////////////
// Reset values and limits
//////////////////////////////////////////
`define TRIG_MODE_RESET  4'b0001
`define DAC_RESET        10'h3ff
`define CALI_DAC_RESET   12'h500
`define HOLD_DELAY_RESET 12'd1560
`define LED_RESET        6'h3f
`define LED_DIM_VALUE    6'h30
`define TRIG_LIMIT       20'd500

`define CONFIG_PULSE_CYCLES     18
`define ASIC_RESET_PULSE_CYCLES 32
`define FORCE_TRIG_PULSE_CYCLES 41

`endif

// File: verilog/usb_cmd_pkg.sv
package usb_cmd_pkg;

  //////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////
  typedef logic [15:0] ctrl_word_t;
  typedef logic [9:0]  dac_code_t;    // Threshold DAC, stored bit-reversed
  typedef logic [11:0] cali_dac_t;
  typedef logic [11:0] hold_delay_t;  // In clock cycles
  typedef logic [3:0]  trig_mode_t;   // One-hot: inside, external, self OR, self AND
  typedef logic [1:0]  cali_sel_t;    // 00 cali, 10 pair 1/2, 11 pair 3/4
  typedef logic [5:0]  led_t;
  typedef logic [63:0] chan_sel_t;
  typedef logic [19:0] trig_count_t;
  typedef logic [11:0] cmd_payload_t;

  // One entry per decoded operation
  typedef enum logic [3:0] {
    op_none,
    op_trig_mode,
    op_trig_run,
    op_hold,
    op_dac12,
    op_dac34,
    op_cali_dac,
    op_hold_delay,
    op_chan_sel,
    op_led,
    op_acq_run,
    op_pulse_config,
    op_pulse_asic_reset,
    op_pulse_force_trig
  } cmd_op_t;

  typedef enum logic {
    pulse_idle,
    pulse_active
  } pulse_state_t;

  typedef struct packed {
    cmd_op_t      op;
    cmd_payload_t payload;  // Low word bits, or mode/level for exact codes
  } decoded_cmd_t;

  typedef struct packed {
    trig_mode_t  trig_mode;
    logic        trig_run;
    logic        hold;
    dac_code_t   dac12;
    dac_code_t   dac34;
    cali_dac_t   cali_dac;
    cali_sel_t   cali_sel;
    hold_delay_t hold_delay;
    chan_sel_t   chan_sel;
    led_t        led;
    logic        acq_run;
  } asic_settings_t;

  typedef struct packed {
    logic config_start;
    logic asic_reset_b;  // Active low
    logic force_trig;
  } pulse_out_t;

endpackage

// File: verilog/usb_cmd_decoder.sv
`timescale 1ns/1ps
`include "usb_cmd_config.svh"

module usb_cmd_decoder (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     cmd_valid,
  input  usb_cmd_pkg::ctrl_word_t  cmd_word,
  output logic                     dec_valid,
  output usb_cmd_pkg::decoded_cmd_t dec_cmd
);

  import usb_cmd_pkg::*;

  logic         word_valid_q;
  ctrl_word_t   word_q;
  cmd_op_t      next_op;
  cmd_payload_t next_payload;

  // Input capture stage
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      word_valid_q <= 1'b0;
    else
      word_valid_q <= cmd_valid;
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid)
      word_q <= cmd_word;
  end

  ////////////////////////////////////////
  // Decode, exact codes before prefixes
  ////////////////////////////////////////
  always_comb
  begin
    next_op      = op_none;
    next_payload = word_q[11:0];
    case (word_q)
      `CMD_TRIG_MODE_INSIDE, `CMD_TRIG_MODE_EXT,
      `CMD_TRIG_MODE_SELF_OR, `CMD_TRIG_MODE_SELF_AND:
      begin
        next_op      = op_trig_mode;
        next_payload = {8'd0, 4'b0001 << (word_q[1:0] - 2'd1)};  // aa04 wraps to bit 3
      end
      `CMD_TRIG_START, `CMD_TRIG_STOP:
      begin
        next_op      = op_trig_run;
        next_payload = {11'd0, word_q[0]};
      end
      `CMD_HOLD_ON, `CMD_HOLD_OFF:
      begin
        next_op      = op_hold;
        next_payload = {11'd0, word_q[0]};
      end
      `CMD_ACQ_START, `CMD_ACQ_STOP:
      begin
        next_op      = op_acq_run;
        next_payload = {11'd0, word_q[0]};
      end
      `CMD_LED_ALL:
      begin
        next_op      = op_led;
        next_payload = {6'd0, `LED_RESET};
      end
      `CMD_LED_DIM:
      begin
        next_op      = op_led;
        next_payload = {6'd0, `LED_DIM_VALUE};
      end
      `CMD_CONFIG_START: next_op = op_pulse_config;
      `CMD_ASIC_RESET:   next_op = op_pulse_asic_reset;
      `CMD_FORCE_TRIG:   next_op = op_pulse_force_trig;
      default:
      begin
        if (word_q[15:12] == `PFX_DAC12)
          next_op = op_dac12;
        else if (word_q[15:12] == `PFX_DAC34)
          next_op = op_dac34;
        else if (word_q[15:12] == `PFX_CALI_DAC)
          next_op = op_cali_dac;
        else if (word_q[15:12] == `PFX_HOLD_DELAY)
          next_op = op_hold_delay;
        else if (word_q[15:8] == `PFX_CHAN_SEL)
          next_op = op_chan_sel;
        else if (word_q[15:8] == `PFX_LED)
          next_op = op_led;  // Pattern in low six bits
      end
    endcase
  end

  // Output stage, unknown words never raise dec_valid
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      dec_valid <= 1'b0;
    else
      dec_valid <= word_valid_q && (next_op != op_none);
  end

  always_ff @(posedge clk)
  begin
    if (word_valid_q)
    begin
      dec_cmd.op      <= next_op;
      dec_cmd.payload <= next_payload;
    end
  end

endmodule

// File: verilog/asic_setting_regs.sv
`timescale 1ns/1ps
`include "usb_cmd_config.svh"

module asic_setting_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        dec_valid,
  input  usb_cmd_pkg::decoded_cmd_t   dec_cmd,
  input  usb_cmd_pkg::trig_count_t    trig_count,
  output usb_cmd_pkg::asic_settings_t settings
);

  import usb_cmd_pkg::*;

  logic acq_cmd;
  logic trig_limit_hit;

  // Threshold DAC bits arrive MSB-last from the host
  function automatic dac_code_t bit_reverse(input logic [9:0] code);
    dac_code_t rev;
    for (int i = 0; i < $bits(dac_code_t); i++)
      rev[i] = code[$bits(dac_code_t) - 1 - i];
    return rev;
  endfunction

  // Channel n in 1..64 selects bit n-1, anything else clears
  function automatic chan_sel_t chan_decode(input logic [7:0] n);
    chan_sel_t sel;
    sel = '0;
    if (n != 8'd0 && n <= 8'd64)
      sel[6'(n - 8'd1)] = 1'b1;
    return sel;
  endfunction

  assign acq_cmd        = dec_valid && (dec_cmd.op == op_acq_run);
  assign trig_limit_hit = (trig_count >= `TRIG_LIMIT);

  ////////////////////////////////////////
  // Static settings
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      settings.trig_mode  <= `TRIG_MODE_RESET;
      settings.trig_run   <= 1'b0;
      settings.hold       <= 1'b0;
      settings.dac12      <= `DAC_RESET;
      settings.dac34      <= `DAC_RESET;
      settings.cali_dac   <= `CALI_DAC_RESET;
      settings.cali_sel   <= 2'b00;
      settings.hold_delay <= `HOLD_DELAY_RESET;
      settings.chan_sel   <= '0;
      settings.led        <= `LED_RESET;
    end
    else if (dec_valid)
    begin
      case (dec_cmd.op)
        op_trig_mode:  settings.trig_mode <= dec_cmd.payload[3:0];
        op_trig_run:   settings.trig_run  <= dec_cmd.payload[0];
        op_hold:       settings.hold      <= dec_cmd.payload[0];
        op_dac12:
        begin
          settings.dac12    <= bit_reverse(dec_cmd.payload[9:0]);
          settings.cali_sel <= 2'b10;  // TA pair 1/2
        end
        op_dac34:
        begin
          settings.dac34    <= bit_reverse(dec_cmd.payload[9:0]);
          settings.cali_sel <= 2'b11;  // TA pair 3/4
        end
        op_cali_dac:
        begin
          settings.cali_dac <= dec_cmd.payload;
          settings.cali_sel <= 2'b00;
        end
        op_hold_delay: settings.hold_delay <= dec_cmd.payload;
        op_chan_sel:   settings.chan_sel   <= chan_decode(dec_cmd.payload[7:0]);
        op_led:        settings.led        <= dec_cmd.payload[5:0];
        default: ;     // Pulses and acq_run handled elsewhere
      endcase
    end
  end

  ////////////////////////////////////////
  // Acquisition run flag
  ////////////////////////////////////////
  // A host command in the same cycle beats the trigger limit
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      settings.acq_run <= 1'b0;
    else if (acq_cmd)
      settings.acq_run <= dec_cmd.payload[0];
    else if (trig_limit_hit)
      settings.acq_run <= 1'b0;  // Enough external triggers collected
  end

endmodule

// File: verilog/asic_pulse_gen.sv
`timescale 1ns/1ps
`include "usb_cmd_config.svh"

module asic_pulse_gen (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      dec_valid,
  input  usb_cmd_pkg::decoded_cmd_t dec_cmd,
  output usb_cmd_pkg::pulse_out_t   pulses
);

  import usb_cmd_pkg::*;

  localparam int num_pulses = 3;

  logic [num_pulses-1:0] start;
  logic [num_pulses-1:0] active;

  // Index 0 config start, 1 ASIC reset, 2 forced trigger
  assign start[0] = dec_valid && (dec_cmd.op == op_pulse_config);
  assign start[1] = dec_valid && (dec_cmd.op == op_pulse_asic_reset);
  assign start[2] = dec_valid && (dec_cmd.op == op_pulse_force_trig);

  ////////////////////////////////////////
  // One FSM per pulse
  ////////////////////////////////////////
  for (genvar i = 0; i < num_pulses; i++)
  begin : g_pulse
    localparam int pulse_cycles = (i == 0) ? `CONFIG_PULSE_CYCLES :
                                  (i == 1) ? `ASIC_RESET_PULSE_CYCLES :
                                             `FORCE_TRIG_PULSE_CYCLES;

    pulse_state_t state;
    logic [5:0]   cycle_cnt;

    always_ff @(posedge clk or negedge reset_n)
    begin
      if (!reset_n)
      begin
        state     <= pulse_idle;
        cycle_cnt <= '0;
      end
      else
      begin
        case (state)
          pulse_idle:
          begin
            cycle_cnt <= '0;
            if (start[i])
              state <= pulse_active;
          end
          pulse_active:
          begin
            // Repeat commands are ignored until the pulse ends
            if (cycle_cnt == 6'(pulse_cycles - 1))
            begin
              state     <= pulse_idle;
              cycle_cnt <= '0;
            end
            else
              cycle_cnt <= cycle_cnt + 6'd1;
          end
          default: state <= pulse_idle;
        endcase
      end
    end

    assign active[i] = (state == pulse_active);
  end

  assign pulses.config_start = active[0];
  assign pulses.asic_reset_b = !active[1];  // Low while resetting the ASIC
  assign pulses.force_trig   = active[2];

endmodule

// File: verilog/usb_command_interpreter.sv
`timescale 1ns/1ps

module usb_command_interpreter (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        cmd_valid,
  input  usb_cmd_pkg::ctrl_word_t     cmd_word,
  input  usb_cmd_pkg::trig_count_t    trig_count,
  output usb_cmd_pkg::asic_settings_t settings,
  output usb_cmd_pkg::pulse_out_t     pulses
);

  import usb_cmd_pkg::*;

  logic         dec_valid;
  decoded_cmd_t dec_cmd;

  // Two-stage decode, then settings and pulses side by side
  usb_cmd_decoder usb_cmd_decoder_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .dec_valid (dec_valid),
    .dec_cmd   (dec_cmd)
  );

  asic_setting_regs asic_setting_regs_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .dec_valid  (dec_valid),
    .dec_cmd    (dec_cmd),
    .trig_count (trig_count),
    .settings   (settings)
  );

  asic_pulse_gen asic_pulse_gen_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .dec_valid (dec_valid),
    .dec_cmd   (dec_cmd),
    .pulses    (pulses)
  );

endmodule

// File: tb/tb_usb_command_interpreter.sv
`timescale 1ns/1ps
`include "usb_cmd_config.svh"

module tb_usb_command_interpreter;

  import usb_cmd_pkg::*;

  logic           clk;
  logic           reset_n;
  logic           cmd_valid;
  ctrl_word_t     cmd_word;
  trig_count_t    trig_count;
  asic_settings_t settings;
  pulse_out_t     pulses;

  int             errors = 0;
  int             timeouts = 0;
  asic_settings_t exp_settings;   // Model state at the settings stage
  logic           d1_valid;
  logic           d2_valid;
  ctrl_word_t     d1_word;
  ctrl_word_t     d2_word;
  int             run_len [3];
  int             pulses_done [3];
  int             done_before [3];
  logic           overlap_seen;
  int             pulse_len [3] = '{`CONFIG_PULSE_CYCLES, `ASIC_RESET_PULSE_CYCLES,
                                    `FORCE_TRIG_PULSE_CYCLES};
  ctrl_word_t     exact_codes [15] = '{
    `CMD_TRIG_MODE_INSIDE, `CMD_TRIG_MODE_EXT, `CMD_TRIG_MODE_SELF_OR, `CMD_TRIG_MODE_SELF_AND,
    `CMD_TRIG_START, `CMD_TRIG_STOP, `CMD_HOLD_ON, `CMD_HOLD_OFF, `CMD_ACQ_START,
    `CMD_ACQ_STOP, `CMD_LED_ALL, `CMD_LED_DIM, `CMD_CONFIG_START, `CMD_ASIC_RESET,
    `CMD_FORCE_TRIG
  };

  usb_command_interpreter usb_command_interpreter_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .trig_count (trig_count),
    .settings   (settings),
    .pulses     (pulses)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic asic_settings_t reset_settings();
    asic_settings_t s;
    s.trig_mode  = `TRIG_MODE_RESET;
    s.trig_run   = 1'b0;
    s.hold       = 1'b0;
    s.dac12      = `DAC_RESET;
    s.dac34      = `DAC_RESET;
    s.cali_dac   = `CALI_DAC_RESET;
    s.cali_sel   = 2'b00;
    s.hold_delay = `HOLD_DELAY_RESET;
    s.chan_sel   = '0;
    s.led        = `LED_RESET;
    s.acq_run    = 1'b0;
    return s;
  endfunction

  function automatic asic_settings_t apply_word(input asic_settings_t prev, input ctrl_word_t w);
    asic_settings_t s;
    logic [7:0]     n;
    s = prev;
    n = w[7:0];
    case (w)
      `CMD_TRIG_MODE_INSIDE:   s.trig_mode = 4'b0001;
      `CMD_TRIG_MODE_EXT:      s.trig_mode = 4'b0010;
      `CMD_TRIG_MODE_SELF_OR:  s.trig_mode = 4'b0100;
      `CMD_TRIG_MODE_SELF_AND: s.trig_mode = 4'b1000;
      `CMD_TRIG_START:         s.trig_run  = 1'b1;
      `CMD_TRIG_STOP:          s.trig_run  = 1'b0;
      `CMD_HOLD_ON:            s.hold      = 1'b1;
      `CMD_HOLD_OFF:           s.hold      = 1'b0;
      `CMD_ACQ_START:          s.acq_run   = 1'b1;
      `CMD_ACQ_STOP:           s.acq_run   = 1'b0;
      `CMD_LED_ALL:            s.led       = `LED_RESET;
      `CMD_LED_DIM:            s.led       = `LED_DIM_VALUE;
      `CMD_CONFIG_START, `CMD_ASIC_RESET, `CMD_FORCE_TRIG: ;  // Pulses only
      default:
      begin
        if (w[15:12] == `PFX_DAC12)
        begin
          s.dac12    = {<<{w[9:0]}};
          s.cali_sel = 2'b10;
        end
        else if (w[15:12] == `PFX_DAC34)
        begin
          s.dac34    = {<<{w[9:0]}};
          s.cali_sel = 2'b11;
        end
        else if (w[15:12] == `PFX_CALI_DAC)
        begin
          s.cali_dac = w[11:0];
          s.cali_sel = 2'b00;
        end
        else if (w[15:12] == `PFX_HOLD_DELAY)
          s.hold_delay = w[11:0];
        else if (w[15:8] == `PFX_CHAN_SEL)
          s.chan_sel = (n >= 8'd1 && n <= 8'd64) ? 64'd1 << (n - 8'd1) : 64'd0;
        else if (w[15:8] == `PFX_LED)
          s.led = w[5:0];
      end
    endcase
    return s;
  endfunction

  function automatic logic is_acq_word(input ctrl_word_t w);
    return (w == `CMD_ACQ_START) || (w == `CMD_ACQ_STOP);
  endfunction

  // Mix of exact codes, prefixed payloads and arbitrary words
  function automatic ctrl_word_t random_word();
    ctrl_word_t w;
    case ($urandom % 8)
      0, 1:    w = exact_codes[4'($urandom % 15)];
      2:       w = {`PFX_DAC12, 12'($urandom)};
      3:       w = {`PFX_DAC34, 12'($urandom)};
      4:       w = {`PFX_CALI_DAC, 12'($urandom)};
      5:       w = {`PFX_HOLD_DELAY, 12'($urandom)};
      6:       w = ($urandom % 2) ? {`PFX_CHAN_SEL, 8'($urandom % 70)} : {`PFX_LED, 8'($urandom)};
      default: w = 16'($urandom);
    endcase
    return w;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
    begin
      errors++;
      $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic check_settings(input asic_settings_t want);
    check_field("trig_mode", 64'(settings.trig_mode), 64'(want.trig_mode));
    check_field("trig_run", 64'(settings.trig_run), 64'(want.trig_run));
    check_field("hold", 64'(settings.hold), 64'(want.hold));
    check_field("dac12", 64'(settings.dac12), 64'(want.dac12));
    check_field("dac34", 64'(settings.dac34), 64'(want.dac34));
    check_field("cali_dac", 64'(settings.cali_dac), 64'(want.cali_dac));
    check_field("cali_sel", 64'(settings.cali_sel), 64'(want.cali_sel));
    check_field("hold_delay", 64'(settings.hold_delay), 64'(want.hold_delay));
    check_field("chan_sel", settings.chan_sel, want.chan_sel);
    check_field("led", 64'(settings.led), 64'(want.led));
    check_field("acq_run", 64'(settings.acq_run), 64'(want.acq_run));
  endtask

  ////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////
  initial
  begin
    logic [2:0] active;
    forever
    begin
      @(posedge clk);
      #1;
      active = {pulses.force_trig, !pulses.asic_reset_b, pulses.config_start};
      if (!reset_n)
      begin
        exp_settings = reset_settings();
        d1_valid     = 1'b0;
        d2_valid     = 1'b0;
        overlap_seen = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
          run_len[i]     = 0;
          pulses_done[i] = 0;
        end
        check_field("pulses in reset", 64'(active), 64'd0);
      end
      else
      begin
        if (d2_valid)
          exp_settings = apply_word(exp_settings, d2_word);
        // Limit loses to an acquisition word at the same edge
        if (trig_count >= `TRIG_LIMIT && !(d2_valid && is_acq_word(d2_word)))
          exp_settings.acq_run = 1'b0;
        d2_valid = d1_valid;
        d2_word  = d1_word;
        d1_valid = cmd_valid;
        d1_word  = cmd_word;
        for (int i = 0; i < 3; i++)
        begin
          if (active[i])
            run_len[i]++;
          else if (run_len[i] != 0)
          begin
            check_field($sformatf("pulse %0d length", i), 64'(run_len[i]), 64'(pulse_len[i]));
            pulses_done[i]++;
            run_len[i] = 0;
          end
        end
        if (active == 3'b111)
          overlap_seen = 1'b1;
      end
      check_settings(exp_settings);
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic send_word(input ctrl_word_t w);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_word  = w;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      cmd_valid = 1'b0;
    end
  endtask

  // Word reaches the settings two edges after it is taken
  task automatic send_and_settle(input ctrl_word_t w);
    send_word(w);
    idle_cycles(3);
  endtask

  task automatic wait_pulses_done();
    int t;
    t = 0;
    while ((pulses_done[0] == done_before[0] || pulses_done[1] == done_before[1] ||
            pulses_done[2] == done_before[2]) && t < 200)
    begin
      @(negedge clk);
      t++;
    end
    if (t >= 200)
    begin
      timeouts++;
      $display("ERROR: the three pulses did not all end within %0d cycles", t);
    end
  endtask

  initial
  begin
    cmd_valid  = 1'b0;
    cmd_word   = '0;
    trig_count = '0;
    reset_n    = 1'b0;
    void'($urandom(57));
    repeat (16) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_field("config_start", 64'(pulses.config_start), 64'd0);
    check_field("asic_reset_b", 64'(pulses.asic_reset_b), 64'd1);
    check_field("force_trig", 64'(pulses.force_trig), 64'd0);

    for (int i = 0; i < 400; i++)
    begin
      if ($urandom % 6 == 0)
        idle_cycles(1);
      else
        send_word(random_word());
    end
    idle_cycles(50);  // Drain pulses

    // Threshold and calibration DACs
    send_and_settle(16'h1001);
    check_field("dac12 reversed", 64'(settings.dac12), 64'h200);
    check_field("cali_sel pair 1/2", 64'(settings.cali_sel), 64'h2);
    send_and_settle(16'h4300);
    check_field("dac34 reversed", 64'(settings.dac34), 64'h003);
    check_field("cali_sel pair 3/4", 64'(settings.cali_sel), 64'h3);
    send_and_settle(16'h5abc);
    check_field("cali_dac", 64'(settings.cali_dac), 64'habc);
    check_field("cali_sel cali", 64'(settings.cali_sel), 64'h0);

    // Channel select edges
    send_and_settle(16'h3405);
    send_and_settle(16'h3400);
    check_field("chan_sel 0", settings.chan_sel, 64'd0);
    send_and_settle(16'h3401);
    check_field("chan_sel 1", settings.chan_sel, 64'h1);
    send_and_settle(16'h3440);
    check_field("chan_sel 64", settings.chan_sel, 64'h8000_0000_0000_0000);
    send_and_settle(16'h3441);
    check_field("chan_sel 65", settings.chan_sel, 64'd0);

    ////////////////////////////////////////
    // Acquisition run flag and trigger limit
    ////////////////////////////////////////
    send_and_settle(`CMD_ACQ_START);
    check_field("acq_run set", 64'(settings.acq_run), 64'd1);
    trig_count = 20'd499;
    idle_cycles(3);
    check_field("acq_run at 499", 64'(settings.acq_run), 64'd1);
    trig_count = 20'd500;
    idle_cycles(2);
    check_field("acq_run at 500", 64'(settings.acq_run), 64'd0);
    trig_count = 20'd0;
    send_word(`CMD_ACQ_START);
    idle_cycles(2);
    trig_count = 20'd500;  // Same edge as the set word
    idle_cycles(1);
    check_field("acq_run set at limit", 64'(settings.acq_run), 64'd1);
    trig_count = 20'd0;
    idle_cycles(3);
    check_field("acq_run kept", 64'(settings.acq_run), 64'd1);

    // Overlapping pulses with repeats
    done_before  = pulses_done;
    overlap_seen = 1'b0;
    send_word(`CMD_CONFIG_START);
    send_word(`CMD_ASIC_RESET);
    send_word(`CMD_FORCE_TRIG);
    idle_cycles(6);
    send_word(`CMD_CONFIG_START);
    send_word(`CMD_ASIC_RESET);
    send_word(`CMD_FORCE_TRIG);
    idle_cycles(1);
    wait_pulses_done();
    idle_cycles(10);
    for (int i = 0; i < 3; i++)
      check_field($sformatf("pulse %0d count", i), 64'(pulses_done[i]), 64'(done_before[i] + 1));
    if (!overlap_seen)
    begin
      errors++;
      $display("FAILED at time %0t: the three pulses never overlapped", $time);
    end

    idle_cycles(5);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: list.f
+incdir+verilog
verilog/usb_cmd_pkg.sv
verilog/usb_cmd_decoder.sv
verilog/asic_setting_regs.sv
verilog/asic_pulse_gen.sv
verilog/usb_command_interpreter.sv
tb/tb_usb_command_interpreter.sv

// File: Makefile
BIN = obj_dir/Vtb_usb_command_interpreter

$(BIN): list.f $(wildcard verilog/*.sv) $(wildcard verilog/*.svh) $(wildcard tb/*.sv)
	verilator --binary --top-module tb_usb_command_interpreter -f list.f \
		-o Vtb_usb_command_interpreter

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
